// File: Bender.yml
package:
  name: dma_system

sources:
  - dma_pkg.sv
  - host_port.sv
  - dma_engine.sv
  - shared_memory.sv
  - dma_system.sv
  - target: test
    files:
      - tb_dma_system.sv

// File: dma_engine.sv
`timescale 1ns/1ps

module dma_engine (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              dma_start,
  input  dma_pkg::dma_cfg_t dma_cfg,
  input  dma_pkg::word_t    rdata,
  output dma_pkg::mem_req_t dma_req,
  output logic              dma_busy,
  output logic              dma_done
);

  dma_pkg::dma_state_t state_q;
  dma_pkg::dma_state_t state_d;
  dma_pkg::dma_cfg_t   cfg_q;   // live pointers and remaining count
  logic                accept;
  logic                step;    // a write goes out this cycle

  assign accept = dma_start && !dma_busy;
  assign step   = (state_q == dma_pkg::write);

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      dma_pkg::idle,
      dma_pkg::finish:
      begin
        if (!dma_start)
          state_d = dma_pkg::idle;
        else if (dma_cfg.count == '0)
          state_d = dma_pkg::finish;  // nothing to move, just report done
        else if (dma_cfg.mode == dma_pkg::dma_fill)
          state_d = dma_pkg::write;
        else
          state_d = dma_pkg::read;
      end

      dma_pkg::read:
      begin
        state_d = dma_pkg::write;
      end

      dma_pkg::write:
      begin
        if (cfg_q.count == dma_pkg::count_t'(1))
          state_d = dma_pkg::finish;
        else if (cfg_q.mode == dma_pkg::dma_fill)
          state_d = dma_pkg::write;
        else
          state_d = dma_pkg::read;
      end

      default:
      begin
        state_d = dma_pkg::idle;
      end
    endcase
  end

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      state_q <= dma_pkg::idle;
    else
      state_q <= state_d;
  end

  // pointers wrap with the address width
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      cfg_q <= dma_cfg;
    end
    else if (step)
    begin
      cfg_q.src   <= cfg_q.src + 1'b1;
      cfg_q.dst   <= cfg_q.dst + 1'b1;
      cfg_q.count <= cfg_q.count - 1'b1;
    end
  end

  assign dma_busy = (state_q == dma_pkg::read) || step;
  assign dma_done = (state_q == dma_pkg::finish);

  // copy writes the word that the previous read just returned
  always_comb
  begin
    dma_req.valid = dma_busy;
    dma_req.we    = step;
    dma_req.addr  = step ? cfg_q.dst : cfg_q.src;
    if (cfg_q.mode == dma_pkg::dma_fill)
      dma_req.wdata = cfg_q.fill;
    else
      dma_req.wdata = rdata;
  end

  a_start_when_free: assert property (@(posedge clk) disable iff (!arst_n)
    dma_start |-> !dma_busy)
    else $error("dma_start while dma_busy is high");

  // the last write moves to finish, so a request always has a word left
  a_req_words_left: assert property (@(posedge clk) disable iff (!arst_n)
    dma_req.valid |-> cfg_q.count != '0)
    else $error("dma request with no words left");

endmodule

// File: dma_pkg.sv
package dma_pkg;

  localparam int word_w    = 32;
  localparam int addr_w    = 10;
  localparam int mem_depth = 1 << addr_w;  // 1024 words
  localparam int count_w   = addr_w + 1;   // full-memory transfer still fits

  typedef logic [word_w-1:0]  word_t;
  typedef logic [addr_w-1:0]  addr_t;
  typedef logic [count_w-1:0] count_t;

  // one access as seen by the shared memory
  typedef struct packed {
    logic  valid;
    logic  we;
    addr_t addr;
    word_t wdata;
  } mem_req_t;

  // host load/store command, same layout as a memory access
  typedef struct packed {
    logic  valid;
    logic  we;
    addr_t addr;
    word_t wdata;
  } host_cmd_t;

  typedef enum logic [0:0] {
    dma_copy = 1'b0,  // word by word from src to dst
    dma_fill = 1'b1   // one value over a run of dst words
  } dma_mode_t;

  typedef struct packed {
    dma_mode_t mode;
    addr_t     src;
    addr_t     dst;
    count_t    count;
    word_t     fill;
  } dma_cfg_t;

  // finish is the done cycle and also accepts a new start
  typedef enum logic [1:0] {
    idle   = 2'd0,
    read   = 2'd1,
    write  = 2'd2,
    finish = 2'd3
  } dma_state_t;

endpackage

// File: dma_system.f
dma_pkg.sv
host_port.sv
dma_engine.sv
shared_memory.sv
dma_system.sv
tb_dma_system.sv

// File: dma_system.sv
`timescale 1ns/1ps

module dma_system (
  input  logic               clk,
  input  logic               arst_n,
  input  dma_pkg::host_cmd_t host_cmd,
  input  logic               dma_start,
  input  dma_pkg::dma_cfg_t  dma_cfg,
  output logic               host_busy,
  output logic               host_rvalid,
  output dma_pkg::word_t     host_rdata,
  output logic               dma_busy,
  output logic               dma_done
);

  dma_pkg::mem_req_t host_req;
  dma_pkg::mem_req_t dma_req;
  logic              host_grant;
  dma_pkg::word_t    rdata;  // shared by both requesters

  host_port i_host_port (
    .clk         (clk),
    .arst_n      (arst_n),
    .host_cmd    (host_cmd),
    .host_grant  (host_grant),
    .rdata       (rdata),
    .host_req    (host_req),
    .host_busy   (host_busy),
    .host_rvalid (host_rvalid),
    .host_rdata  (host_rdata)
  );

  dma_engine i_dma_engine (
    .clk       (clk),
    .arst_n    (arst_n),
    .dma_start (dma_start),
    .dma_cfg   (dma_cfg),
    .rdata     (rdata),
    .dma_req   (dma_req),
    .dma_busy  (dma_busy),
    .dma_done  (dma_done)
  );

  shared_memory i_shared_memory (
    .clk        (clk),
    .arst_n     (arst_n),
    .host_req   (host_req),
    .dma_req    (dma_req),
    .dma_busy   (dma_busy),
    .host_grant (host_grant),
    .rdata      (rdata)
  );

endmodule

// File: dma_system_tests.txt
# W addr data | R addr expected | C src dst count | F dst count fill
# B addr data = host write issued right after the next C or F starts; all values hex
W 000 11111111
R 000 11111111
W 001 22222222
W 002 33333333
R 001 22222222
R 002 33333333
# copy with guard words around the destination
W 010 A0000010
W 011 A0000011
W 012 A0000012
W 013 A0000013
W 01F 0BADF00D
W 024 0BADF00D
C 010 020 4
R 01F 0BADF00D
R 020 A0000010
R 021 A0000011
R 022 A0000012
R 023 A0000013
R 024 0BADF00D
# fill with guards
W 03F 12121212
W 048 34343434
F 040 8 A5A5A5A5
R 03F 12121212
R 040 A5A5A5A5
R 043 A5A5A5A5
R 047 A5A5A5A5
R 048 34343434
# zero-length transfers
W 050 DEADBEEF
C 010 050 0
B 051 51515151
F 050 0 77777777
R 050 DEADBEEF
R 051 51515151
# host write during a DMA, same address and elsewhere
B 021 CAFEF00D
C 010 020 4
R 020 A0000010
R 021 CAFEF00D
R 022 A0000012
B 060 600DCAFE
F 070 3 5A5A5A5A
R 060 600DCAFE
R 070 5A5A5A5A
R 072 5A5A5A5A
# forward overlap
W 100 B0000100
W 101 B0000101
W 102 B0000102
C 100 102 3
R 101 B0000101
R 102 B0000100
R 103 B0000101
R 104 B0000100
# wrapping source and destination
W 3FE C00003FE
W 3FF C00003FF
C 3FE 200 3
R 200 C00003FE
R 201 C00003FF
R 202 11111111
F 3FF 2 55AA55AA
R 3FF 55AA55AA
R 000 55AA55AA
R 001 22222222
R 3FE C00003FE
# backward overlap
C 200 1FF 3
R 1FF C00003FE
R 200 C00003FF
R 201 11111111
R 202 11111111
# longer runs
W 2FF 22FF22FF
W 340 33403340
F 300 40 0F0F0F0F
R 2FF 22FF22FF
R 300 0F0F0F0F
R 33F 0F0F0F0F
R 340 33403340
C 300 380 40
R 380 0F0F0F0F
R 3BF 0F0F0F0F

// File: host_port.sv
`timescale 1ns/1ps

module host_port (
  input  logic               clk,
  input  logic               arst_n,
  input  dma_pkg::host_cmd_t host_cmd,
  input  logic               host_grant,
  input  dma_pkg::word_t     rdata,
  output dma_pkg::mem_req_t  host_req,
  output logic               host_busy,
  output logic               host_rvalid,
  output dma_pkg::word_t     host_rdata
);

  dma_pkg::host_cmd_t pend_q;     // valid marks a command still waiting for the bus
  logic               issue;
  logic               rd_wait_q;  // read went out last cycle, rdata is ours now

  assign issue = pend_q.valid && host_grant;

  // request is presented only in the cycle the bus is ours
  always_comb
  begin
    host_req.valid = issue;
    host_req.we    = pend_q.we;
    host_req.addr  = pend_q.addr;
    host_req.wdata = pend_q.wdata;
  end

  assign host_busy = pend_q.valid || rd_wait_q;

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      pend_q.valid <= 1'b0;
    end
    else if (host_cmd.valid)
    begin
      pend_q <= host_cmd;
    end
    else if (issue)
    begin
      pend_q.valid <= 1'b0;
    end
  end

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      rd_wait_q   <= 1'b0;
      host_rvalid <= 1'b0;
    end
    else
    begin
      rd_wait_q   <= issue && !pend_q.we;
      host_rvalid <= rd_wait_q;  // one pulse per read
    end
  end

  always_ff @(posedge clk)
  begin
    if (rd_wait_q)
      host_rdata <= rdata;
  end

  // host side must wait for host_busy to drop before the next command
  a_cmd_not_busy: assert property (@(posedge clk) disable iff (!arst_n)
    host_cmd.valid |-> !host_busy)
    else $error("host_cmd.valid while host_busy is high");

endmodule

// File: shared_memory.sv
`timescale 1ns/1ps

module shared_memory (
  input  logic              clk,
  input  logic              arst_n,
  input  dma_pkg::mem_req_t host_req,
  input  dma_pkg::mem_req_t dma_req,
  input  logic              dma_busy,
  output logic              host_grant,
  output dma_pkg::word_t    rdata
);

  dma_pkg::word_t    mem [dma_pkg::mem_depth];
  dma_pkg::mem_req_t bus;
  logic              host_acc;

  assign host_acc = host_req.valid && host_grant;

  // dma owns the bus for as long as it is busy
  always_comb
  begin
    if (dma_busy)
    begin
      bus = dma_req;
    end
    else
    begin
      bus       = host_req;
      bus.valid = host_acc;
    end
  end

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      host_grant <= 1'b1;
    else
      host_grant <= !dma_busy;
  end

  // rdata holds until the next accepted read
  always_ff @(posedge clk)
  begin
    if (bus.valid)
    begin
      if (bus.we)
        mem[bus.addr] <= bus.wdata;
      else
        rdata <= mem[bus.addr];
    end
  end

  // grant lags dma_busy by a cycle, so a host access in that gap would be lost
  a_host_outside_dma: assert property (@(posedge clk) disable iff (!arst_n)
    host_acc |-> !dma_busy)
    else $error("host request accepted while the DMA owns the bus");

endmodule

// File: tb_dma_system.sv
`timescale 1ns/1ps

module tb_dma_system;

  localparam int          clk_period      = 10;
  localparam int          watchdog_margin = 50;
  localparam int          wait_limit      = 2 * dma_pkg::mem_depth + watchdog_margin;
  localparam logic [15:0] lfsr_seed       = 16'd94;
  localparam              test_file       = "dma_system_tests.txt";

  logic               clk;
  logic               arst_n;
  dma_pkg::host_cmd_t host_cmd;
  logic               dma_start;
  dma_pkg::dma_cfg_t  dma_cfg;
  logic               host_busy;
  logic               host_rvalid;
  dma_pkg::word_t     host_rdata;
  logic               dma_busy;
  logic               dma_done;

  logic [7:0]     op_q  [$];
  logic [31:0]    arg_a [$];
  logic [31:0]    arg_b [$];
  logic [31:0]    arg_c [$];
  dma_pkg::word_t model [dma_pkg::mem_depth];  // expected memory contents
  bit             known [dma_pkg::mem_depth];
  logic [15:0]    lfsr;
  int             errors      = 0;
  int             checks      = 0;
  int             rvalid_seen = 0;
  int             rvalid_exp  = 0;
  int             done_seen   = 0;
  int             done_exp    = 0;
  bit             loaded      = 1'b0;
  bit             b_pending   = 1'b0;  // host write armed for the next DMA start
  dma_pkg::addr_t b_addr;
  dma_pkg::word_t b_data;

  dma_system i_dma_system (
    .clk         (clk),
    .arst_n      (arst_n),
    .host_cmd    (host_cmd),
    .dma_start   (dma_start),
    .dma_cfg     (dma_cfg),
    .host_busy   (host_busy),
    .host_rvalid (host_rvalid),
    .host_rdata  (host_rdata),
    .dma_busy    (dma_busy),
    .dma_done    (dma_done)
  );

  initial
  begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  task automatic report_value(input string name, input logic [31:0] exp, input logic [31:0] got);
    $display("FAIL %s expected %h got %h at %0t", name, exp, got, $time);
    errors++;
  endtask

  task automatic report_text(input string what);
    $display("ERROR %s at %0t", what, $time);
    errors++;
  endtask

  task automatic load_tests(output bit ok);
    int               fd;
    int               n;
    logic [8*16-1:0]  tok;
    logic [8*256-1:0] rest;
    logic [31:0]      a;
    logic [31:0]      b;
    logic [31:0]      c;
    fd = $fopen(test_file, "r");
    ok = (fd != 0);
    if (ok)
    begin
      while (!$feof(fd))
      begin
        tok = '0;
        c   = '0;
        n   = $fscanf(fd, "%s", tok);
        if (n == 1)
        begin
          case (tok)
            "#": n = $fgets(rest, fd);  // rest of a comment line
            "W", "R", "B":
            begin
              n = $fscanf(fd, "%h %h", a, b);
              if (n != 2)
                report_text("malformed line in the test file");
              op_q.push_back(tok[7:0]);
              arg_a.push_back(a);
              arg_b.push_back(b);
              arg_c.push_back(c);
            end
            "C", "F":
            begin
              n = $fscanf(fd, "%h %h %h", a, b, c);
              if (n != 3)
                report_text("malformed line in the test file");
              op_q.push_back(tok[7:0]);
              arg_a.push_back(a);
              arg_b.push_back(b);
              arg_c.push_back(c);
            end
            default: report_text("unknown opcode in the test file");
          endcase
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic check_reset();
    checks++;
    if (host_busy !== 1'b0)
      report_value("host_busy", 0, host_busy);
    if (host_rvalid !== 1'b0)
      report_value("host_rvalid", 0, host_rvalid);
    if (dma_busy !== 1'b0)
      report_value("dma_busy", 0, dma_busy);
    if (dma_done !== 1'b0)
      report_value("dma_done", 0, dma_done);
    if (i_dma_system.host_grant !== 1'b1)
      report_value("host_grant", 1, i_dma_system.host_grant);
  endtask

  task automatic host_write(input dma_pkg::addr_t addr, input dma_pkg::word_t data);
    int waited;
    host_cmd.valid = 1'b1;
    host_cmd.we    = 1'b1;
    host_cmd.addr  = addr;
    host_cmd.wdata = data;
    @(negedge clk);
    host_cmd.valid = 1'b0;
    waited = 0;
    if (!host_busy)
      report_text("host_busy did not rise after a host write");
    while (host_busy && waited < wait_limit)
    begin
      @(negedge clk);
      waited++;
    end
    if (host_busy)
      report_text("host write never completed");
    model[addr] = data;
    known[addr] = 1'b1;
  endtask

  task automatic host_read(input dma_pkg::addr_t addr, input dma_pkg::word_t exp);
    int             waited;
    int             pulses;
    dma_pkg::word_t got;
    host_cmd.valid = 1'b1;
    host_cmd.we    = 1'b0;
    host_cmd.addr  = addr;
    host_cmd.wdata = '0;
    @(negedge clk);
    host_cmd.valid = 1'b0;
    waited = 0;
    pulses = 0;
    checks++;
    rvalid_exp++;
    if (!host_busy)
      report_text("host_busy did not rise after a host read");
    while (host_busy && waited < wait_limit)
    begin
      @(negedge clk);
      waited++;
      if (host_rvalid)
      begin
        pulses++;
        got = host_rdata;
        if (host_busy)
          report_text("host_rvalid came while host_busy stayed high");
      end
    end
    if (host_busy)
      report_text("host read never completed");
    if (pulses != 1)
      report_text($sformatf("host_rvalid pulsed %0d times for one read", pulses));
    if (got !== exp)
      report_value($sformatf("host_rdata[%h]", addr), exp, got);
    if (known[addr] && model[addr] !== exp)
      report_text($sformatf("test file expects %h at %h, the model holds %h",
                            exp, addr, model[addr]));
  endtask

  task automatic run_dma(input dma_pkg::dma_mode_t mode, input dma_pkg::addr_t src,
                         input dma_pkg::addr_t dst, input dma_pkg::count_t count,
                         input dma_pkg::word_t fill);
    int             waited;
    bit             got_done;
    bit             prev_busy;
    bit             with_host;
    bit             host_armed;
    dma_pkg::addr_t s;
    dma_pkg::addr_t d;
    with_host     = b_pending;
    b_pending     = 1'b0;
    host_armed    = 1'b0;
    dma_start     = 1'b1;
    dma_cfg.mode  = mode;
    dma_cfg.src   = src;
    dma_cfg.dst   = dst;
    dma_cfg.count = count;
    dma_cfg.fill  = fill;
    @(negedge clk);
    dma_start = 1'b0;
    checks++;
    done_exp++;
    if (count != 0 && !dma_busy)
      report_text("dma_busy did not rise after dma_start");
    if (with_host)
    begin
      host_cmd.valid = 1'b1;  // host write lands while the DMA holds the bus
      host_cmd.we    = 1'b1;
      host_cmd.addr  = b_addr;
      host_cmd.wdata = b_data;
    end
    waited    = 0;
    got_done  = 1'b0;
    prev_busy = 1'b0;
    while (!got_done && waited < wait_limit)
    begin
      if (dma_done)
      begin
        got_done = 1'b1;
        if (dma_busy)
          report_text("dma_done while dma_busy is still high");
        if (count != 0 && !prev_busy)
          report_text("dma_done did not coincide with dma_busy falling");
        if (count == 0 && waited != 0)
          report_text("dma_done late for a zero-length transfer");
      end
      else
      begin
        if (prev_busy && !dma_busy)
          report_text("dma_busy fell without dma_done");
        if (host_armed && dma_busy && !host_busy)
          report_text("host write finished while the DMA owned the bus");
        prev_busy = dma_busy;
        @(negedge clk);
        waited++;
        host_cmd.valid = 1'b0;
        host_armed     = with_host;
      end
    end
    if (!got_done)
      report_text($sformatf("no dma_done within %0d cycles", wait_limit));
    if (host_cmd.valid)
    begin
      @(negedge clk);
      host_cmd.valid = 1'b0;
    end
    waited = 0;
    while (host_busy && waited < wait_limit)
    begin
      @(negedge clk);
      waited++;
    end
    if (host_busy)
      report_text("host write held during the DMA never completed");

    // ascending word order, so overlapping copies see words already moved
    s = src;
    d = dst;
    for (int i = 0; i < count; i++)
    begin
      if (mode == dma_pkg::dma_fill)
      begin
        model[d] = fill;
        known[d] = 1'b1;
      end
      else
      begin
        model[d] = model[s];
        known[d] = known[s];
      end
      s++;
      d++;
    end
    if (with_host)
    begin
      model[b_addr] = b_data;
      known[b_addr] = 1'b1;
    end
  endtask

  task automatic idle_gap();
    int n;
    n = 0;
    repeat (2)
    begin
      lfsr = lfsr_next(lfsr);
      n    = (n << 1) | lfsr[0];
    end
    repeat (n) @(negedge clk);
  endtask

  always @(negedge clk)
  begin
    if (arst_n && host_rvalid)
      rvalid_seen++;
    if (arst_n && dma_done)
      done_seen++;
  end

  initial
  begin : watchdog
    wait (loaded);
    repeat ((op_q.size() + 1) * wait_limit) @(posedge clk);
    $display("watchdog expired, the run hung");
    $display("%0d checks, %0d errors", checks, errors + 1);
    $display("Something failed");
    $finish;
  end

  initial
  begin : main
    bit ok;
    arst_n    = 1'b0;
    host_cmd  = '0;
    dma_start = 1'b0;
    dma_cfg   = '0;
    lfsr      = lfsr_seed;
    load_tests(ok);
    if (!ok)
    begin
      $display("cannot open %s", test_file);
      $display("Something failed");
      $finish;
    end
    else
    begin
      loaded = 1'b1;
      repeat (2) @(posedge clk);
      @(negedge clk);
      check_reset();
      arst_n = 1'b1;
      for (int i = 0; i < op_q.size(); i++)
      begin
        case (op_q[i])
          "W": host_write(dma_pkg::addr_t'(arg_a[i]), arg_b[i]);
          "R": host_read(dma_pkg::addr_t'(arg_a[i]), arg_b[i]);
          "B":
          begin
            b_pending = 1'b1;
            b_addr    = dma_pkg::addr_t'(arg_a[i]);
            b_data    = arg_b[i];
          end
          "C": run_dma(dma_pkg::dma_copy, dma_pkg::addr_t'(arg_a[i]),
                       dma_pkg::addr_t'(arg_b[i]), dma_pkg::count_t'(arg_c[i]), '0);
          "F": run_dma(dma_pkg::dma_fill, '0, dma_pkg::addr_t'(arg_a[i]),
                       dma_pkg::count_t'(arg_b[i]), arg_c[i]);
          default: report_text("unknown opcode reached the run loop");
        endcase
        if (op_q[i] != "B")
          idle_gap();
      end
      if (b_pending)
        report_text("a B line has no DMA after it");
      repeat (4) @(negedge clk);
      if (rvalid_seen != rvalid_exp)
        report_text($sformatf("host_rvalid pulsed %0d times, %0d reads were issued",
                              rvalid_seen, rvalid_exp));
      if (done_seen != done_exp)
        report_text($sformatf("dma_done pulsed %0d times, %0d transfers were started",
                              done_seen, done_exp));
      $display("%0d checks, %0d errors", checks, errors);
      if (errors == 0)
        $display("Everything OK");
      else
        $display("Something failed");
      $finish;
    end
  end

endmodule
